/* Bender.yml */
package:
  name: jackal_audio

dependencies: {}

sources:
  # shared types and constants come first
  - logic/jackal_audio_pkg.sv
  - logic/lpf_control.sv
  - logic/iir_1st_order.sv
  - logic/jackal_lpf.sv
  - logic/jackal_audio_top.sv

  # testbench, top module jackal_audio_tb
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/jackal_audio_tb.sv

/* filelist.f */
+incdir+sim
logic/jackal_audio_pkg.sv
logic/lpf_control.sv
logic/iir_1st_order.sv
logic/jackal_lpf.sv
logic/jackal_audio_top.sv
sim/jackal_audio_tb.sv

/* logic/iir_1st_order.sv */
// coefficients are fixed at elaboration and the state only advances on clocks with sample_en high
`timescale 1ns/100ps

module iir_1st_order import jackal_audio_pkg::*; #(
	parameter coef_t a2 = lpf1_a2,
	parameter coef_t b1 = lpf1_b1,
	parameter coef_t b2 = lpf1_b2
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    sample_en,
	input  sample_t x,
	output sample_t y
);

	// ------------------------------------------------------------
	// section state
	// ------------------------------------------------------------

	// previous input, the previous output is y itself
	sample_t x_prev;
	sample_t y_next;

	// full precision terms of the difference equation
	acc_t    term_b1;
	acc_t    term_b2;
	acc_t    term_a2;
	acc_t    acc;
	acc_t    acc_shift;

	// ------------------------------------------------------------
	// difference equation
	// ------------------------------------------------------------

	// y[n] = b1*x[n] + b2*x[n-1] - a2*y[n-1], all in Q15
	// every operand is widened to acc_t first so the products keep their sign
	always_comb begin
		term_b1 = acc_t'(b1) * acc_t'(x);
		term_b2 = acc_t'(b2) * acc_t'(x_prev);
		term_a2 = acc_t'(a2) * acc_t'(y);
		acc     = term_b1 + term_b2 - term_a2;
	end

	// drop the Q15 fraction, arithmetic shift keeps negative values rounding down
	assign acc_shift = acc >>> coef_frac;

	// clamp to the sample range, a full scale step would otherwise wrap
	// around and produce a loud click of the opposite sign
	always_comb begin
		if (acc_shift > acc_t'(sample_max)) begin
			y_next = sample_max;
		end else if (acc_shift < acc_t'(sample_min)) begin
			y_next = sample_min;
		end else begin
			y_next = sample_t'(acc_shift);
		end
	end

	// ------------------------------------------------------------
	// state update
	// ------------------------------------------------------------

	// the output register changes on the edge that closes the strobe clock
	// which gives a cascade one sample of delay per section
	always_ff @(posedge clk) begin
		if (reset) begin
			x_prev <= '0;
			y      <= '0;
		end else if (sample_en) begin
			x_prev <= x;
			y      <= y_next;
		end
	end

endmodule

/* logic/jackal_audio_pkg.sv */
// coefficients are fixed Q15 values for a 768 kHz sample rate, so a different clock needs new values
package jackal_audio_pkg;

	// ------------------------------------------------------------
	// sample and arithmetic types
	// ------------------------------------------------------------

	// one signed 16-bit audio sample, as delivered by the sound source
	typedef logic signed [15:0] sample_t;

	// filter coefficient in Q15, so 32768 stands for a gain of 1.0
	// the two spare bits leave room for values just above unity
	typedef logic signed [17:0] coef_t;

	// sum of three 18x16 products, wide enough that nothing can wrap
	typedef logic signed [35:0] acc_t;

	// fractional bits of the coefficients, removed after the sum
	localparam int coef_frac = 15;

	// clamp limits applied to each section result
	localparam sample_t sample_max = 16'sh7fff;
	localparam sample_t sample_min = 16'sh8000;

	// ------------------------------------------------------------
	// decimation
	// ------------------------------------------------------------

	// 49.152 MHz divided by 64 gives a 768 kHz sample strobe
	localparam int sample_div = 64;
	localparam int cnt_w      = $clog2(sample_div);

	// the counter sits in idle while reset is high and for one clock after it
	typedef enum logic {
		idle,
		run
	} ctrl_state_t;

	// ------------------------------------------------------------
	// section coefficients
	// ------------------------------------------------------------

	// first section, pole near 0.9692 and b1 = b2 for a zero at Nyquist
	localparam coef_t lpf1_a2 = -18'sd31758;
	localparam coef_t lpf1_b1 = 18'sd505;
	localparam coef_t lpf1_b2 = 18'sd505;

	// second section, a slightly higher corner than the first
	localparam coef_t lpf2_a2 = -18'sd31544;
	localparam coef_t lpf2_b1 = 18'sd612;
	localparam coef_t lpf2_b2 = 18'sd612;

endpackage

/* logic/jackal_audio_top.sv */
// the inputs are levels sampled on the internal strobe, and out holds for 64 clocks between samples
`timescale 1ns/100ps

module jackal_audio_top import jackal_audio_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    select,
	input  sample_t in1,
	input  sample_t in2,
	output sample_t out
);

	// ------------------------------------------------------------
	// internal strobes
	// ------------------------------------------------------------

	// sample tick, one clock high every sample_div clocks
	logic sample_en;

	// select as it was on the last tick
	logic select_q;

	// ------------------------------------------------------------
	// control and datapath
	// ------------------------------------------------------------

	// divides the clock down and aligns select to the sample boundary
	lpf_control u_control (
		.clk      (clk),
		.reset    (reset),
		.select   (select),
		.sample_en(sample_en),
		.select_q (select_q)
	);

	// source mux, two first order sections and the tap mux
	jackal_lpf u_lpf (
		.clk      (clk),
		.reset    (reset),
		.sample_en(sample_en),
		.select_q (select_q),
		.in1      (in1),
		.in2      (in2),
		.out      (out)
	);

endmodule

/* logic/jackal_lpf.sv */
// source and tap selection are plain muxes, so select_q must already be aligned to the sample strobe
`timescale 1ns/100ps

module jackal_lpf import jackal_audio_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    sample_en,
	input  logic    select_q,
	input  sample_t in1,
	input  sample_t in2,
	output sample_t out
);

	// ------------------------------------------------------------
	// source selection
	// ------------------------------------------------------------

	sample_t audio_pre_lpf1;
	sample_t audio_post_lpf1;
	sample_t audio_post_lpf2;

	// select high feeds in1 into the chain, low feeds in2
	assign audio_pre_lpf1 = select_q ? in1 : in2;

	// ------------------------------------------------------------
	// cascaded sections
	// ------------------------------------------------------------

	// first 6 dB per octave section
	iir_1st_order #(
		.a2(lpf1_a2),
		.b1(lpf1_b1),
		.b2(lpf1_b2)
	) lpf1_6db (
		.clk      (clk),
		.reset    (reset),
		.sample_en(sample_en),
		.x        (audio_pre_lpf1),
		.y        (audio_post_lpf1)
	);

	// second section runs on the registered output of the first
	// the pair together gives a 12 dB per octave roll-off
	iir_1st_order #(
		.a2(lpf2_a2),
		.b1(lpf2_b1),
		.b2(lpf2_b2)
	) lpf2_6db (
		.clk      (clk),
		.reset    (reset),
		.sample_en(sample_en),
		.x        (audio_post_lpf1),
		.y        (audio_post_lpf2)
	);

	// ------------------------------------------------------------
	// output tap
	// ------------------------------------------------------------

	// select high takes the single section, low takes the full cascade
	// both taps and select_q change on the same edge, so out moves once per sample
	assign out = select_q ? audio_post_lpf1 : audio_post_lpf2;

endmodule

/* logic/lpf_control.sv */
// the strobe period is fixed by sample_div, and select is sampled only on the strobe clock
`timescale 1ns/100ps

module lpf_control import jackal_audio_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic select,
	output logic sample_en,
	output logic select_q
);

	// ------------------------------------------------------------
	// decimation counter
	// ------------------------------------------------------------

	ctrl_state_t           state;
	logic [cnt_w-1:0]      count;

	// the state machine only exists to hold the count for one clock after reset
	// so the first strobe lands on the 64th clock after release
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			count <= '0;
		end else begin
			case (state)
				idle: begin
					// counting starts from zero on the next clock
					state <= run;
					count <= '0;
				end
				run: begin
					if (count == cnt_w'(sample_div - 1)) begin
						count <= '0;
					end else begin
						count <= count + 1'b1;
					end
				end
				default: begin
					state <= idle;
					count <= '0;
				end
			endcase
		end
	end

	// one clock wide strobe on the last count of each period
	// the idle state keeps it low through reset and the clock after it
	assign sample_en = (state == run) && (count == cnt_w'(sample_div - 1));

	// ------------------------------------------------------------
	// select register
	// ------------------------------------------------------------

	// select is taken on the same edge that updates the filter sections
	// so the source and the output tap switch on a sample boundary only
	always_ff @(posedge clk) begin
		if (reset) begin
			select_q <= 1'b0;
		end else if (sample_en) begin
			select_q <= select;
		end
	end

endmodule

/* sim/jackal_audio_tb_tasks.svh */
// included inside jackal_audio_tb; inputs change 1 ns after a rising edge and out is checked there
`ifndef jackal_audio_tb_tasks_svh
`define jackal_audio_tb_tasks_svh

	// ------------------------------------------------------------
	// checking and clocking helpers
	// ------------------------------------------------------------

	task automatic stop_on_error();
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input longint got, input longint expected, input string msg);
		if (got != expected) begin
			$display("Mismatch at time %0t: %s, got %0d expected %0d", $time, msg, got, expected);
			stop_on_error();
		end
	endtask

	// every drive and every sample happens 1 ns after the edge
	task automatic advance_clock();
		@(posedge clk);
		#1;
	endtask

	// out must hold its value on every clock that is not a strobe edge
	task automatic wait_clocks(input int n);
		repeat (n) begin
			advance_clock();
			check_value(out, model_out(), "out changed between sample ticks");
		end
	endtask

	// runs up to the next strobe clock, steps the model and checks the new output
	task automatic step_sample();
		int guard;
		guard = 0;
		while (!strobe_clock()) begin
			check_value(out, model_out(), "out changed between sample ticks");
			advance_clock();
			guard++;
			if (guard > 2 * sample_div) begin
				$display("Timeout: no sample tick came within %0d clocks", 2 * sample_div);
				stop_on_error();
			end
		end
		check_value(out, model_out(), "out changed before the sample edge");
		update_model();
		advance_clock();
		check_value(out, model_out(), "out differs from the reference model after a tick");
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic idle_after_reset();
		in1    = '0;
		in2    = '0;
		select = 1'b0;
		check_value(out, 0, "out is not zero after reset");
		repeat (20) begin
			step_sample();
			check_value(out, 0, "out left zero with silent inputs");
		end
	endtask

	task automatic two_stage_step();
		sample_t last;
		select = 1'b0;
		in2    = 16'sd16000;
		repeat (2000) step_sample();
		last = model_out();
		step_sample();
		check_value(out, last, "step response still moving after 2000 ticks");
		// unity DC gain less the rounding stall of both sections
		check_value((out <= 16000) && (out >= 16000 - dead1 - dead2), 1,
		            "two stage step response did not settle near 16000");
	endtask

	task automatic one_stage_path();
		select = 1'b1;
		in1    = -16'sd12000;
		in2    = 16'sd9000;
		repeat (500) step_sample();
		// in2 is far away, so landing near in1 shows the source mux picked in1
		check_value((out >= -12000 - dead1) && (out <= -12000 + dead1), 1,
		            "one stage path did not follow in1");
	endtask

	task automatic select_timing();
		repeat (6) begin
			step_sample();
			wait_clocks(9);
			select = ~select;
			wait_clocks(20);
			step_sample();
			step_sample();
		end
	endtask

	task automatic saturation_steps();
		sample_t full;
		for (int round = 0; round < 8; round++) begin
			full   = (round % 2 == 0) ? 16'sh7fff : 16'sh8000;
			in1    = full;
			in2    = full;
			select = (round < 4);
			repeat (60) step_sample();
		end
	endtask

	task automatic random_audio();
		repeat (300) begin
			in1    = sample_t'($random(seed));
			in2    = sample_t'($random(seed));
			select = 1'($random(seed));
			step_sample();
		end
	endtask

`endif

/* sim/jackal_audio_tb.sv */
// the model assumes the first strobe on the 64th clock after reset release, then one every 64 clocks
`timescale 1ns/100ps

module jackal_audio_tb import jackal_audio_pkg::*; ();

	// ------------------------------------------------------------
	// DUT signals and testbench state
	// ------------------------------------------------------------

	logic    clk;
	logic    reset;
	logic    select;
	sample_t in1;
	sample_t in2;
	sample_t out;

	// clocks since reset release, a nonzero multiple of sample_div is a strobe clock
	int      clk_cnt;
	integer  seed;

	// model state of both sections and of the registered select
	sample_t m_x1_prev;
	sample_t m_y1;
	sample_t m_x2_prev;
	sample_t m_y2;
	logic    m_sel;

	// floor rounding stalls each section this many LSB short of a rising target
	localparam int dead1 = 32768 / (int'(lpf1_b1) + int'(lpf1_b2));
	localparam int dead2 = 32768 / (int'(lpf2_b1) + int'(lpf2_b2));

	jackal_audio_top uut (
		.clk   (clk),
		.reset (reset),
		.select(select),
		.in1   (in1),
		.in2   (in2),
		.out   (out)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// the testbench's own tick reference, independent of the DUT counter
	always @(posedge clk) begin
		if (reset) begin
			clk_cnt <= 0;
		end else begin
			clk_cnt <= clk_cnt + 1;
		end
	end

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------

	// true on the clock where the DUT strobe is expected high
	function automatic logic strobe_clock();
		return (clk_cnt != 0) && (clk_cnt % sample_div == 0);
	endfunction

	// one step of a section: (b1*x + b2*x_prev - a2*y_prev) >>> 15, then clamp
	function automatic sample_t section_next(sample_t x, sample_t x_prev, sample_t y_prev,
	                                         coef_t a2, coef_t b1, coef_t b2);
		acc_t sum;
		acc_t scaled;
		sum    = acc_t'(b1) * acc_t'(x) + acc_t'(b2) * acc_t'(x_prev);
		sum    = sum - acc_t'(a2) * acc_t'(y_prev);
		scaled = sum >>> 15;
		if (scaled > 32767) begin
			return 16'sh7fff;
		end
		if (scaled < -32768) begin
			return 16'sh8000;
		end
		return sample_t'(scaled);
	endfunction

	// tap chosen by the model select
	function automatic sample_t model_out();
		return m_sel ? m_y1 : m_y2;
	endfunction

	// applied on the strobe clock, mirrors what the DUT loads on the closing edge
	// the source mux still uses the old select, the new one only moves the tap
	function automatic void update_model();
		sample_t x1;
		sample_t y1_new;
		sample_t y2_new;
		x1        = m_sel ? in1 : in2;
		y1_new    = section_next(x1, m_x1_prev, m_y1, lpf1_a2, lpf1_b1, lpf1_b2);
		y2_new    = section_next(m_y1, m_x2_prev, m_y2, lpf2_a2, lpf2_b1, lpf2_b2);
		m_x1_prev = x1;
		m_x2_prev = m_y1;
		m_y1      = y1_new;
		m_y2      = y2_new;
		m_sel     = select;
	endfunction

	`include "jackal_audio_tb_tasks.svh"

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin
		seed      = 32'h9ffb_52a9;
		reset     = 1'b1;
		select    = 1'b0;
		in1       = '0;
		in2       = '0;
		m_x1_prev = '0;
		m_y1      = '0;
		m_x2_prev = '0;
		m_y2      = '0;
		m_sel     = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		idle_after_reset();
		two_stage_step();
		one_stage_path();
		select_timing();
		saturation_steps();
		random_audio();
		$display("Verification passed");
		$finish;
	end

endmodule
